// File: verilog/ebusPkg.sv
`default_nettype none

// Bus-level definitions shared by every EBUS device and the top level
package ebusPkg;

  // Width of one EBUS word
  localparam int dataWidth = 36;

  // Device select and function code widths
  localparam int csWidth = 7;
  localparam int funcWidth = 3;

  // Function codes carried on ebusFunc during a demand
  localparam logic [funcWidth-1:0] funcCono = 3'd0;
  localparam logic [funcWidth-1:0] funcConi = 3'd1;
  localparam logic [funcWidth-1:0] funcDatao = 3'd2;
  localparam logic [funcWidth-1:0] funcDatai = 3'd3;

  // Layout of a CONO word as the devices decode it, most significant field first
  typedef struct packed {
    logic [16:0] spare;
    logic [6:0] clearBits;
    logic [6:0] setBits;
    logic turnOff;
    logic turnOn;
    logic [2:0] level;
  } condWord;

  // One bus word seen either as raw data or as a condition word
  typedef union packed {
    logic [dataWidth-1:0] data;
    condWord cond;
  } ebusWord;

endpackage

`default_nettype wire

// File: verilog/devicePkg.sv
`default_nettype none

// Device numbering and per-device sizes
package devicePkg;

  // Device numbers compared against ebusCs
  localparam logic [ebusPkg::csWidth-1:0] devApr = 7'd0;
  localparam logic [ebusPkg::csWidth-1:0] devPi = 7'd1;
  localparam logic [ebusPkg::csWidth-1:0] devMtr = 7'd2;

  // Number of error flags held in the APR condition block
  localparam int aprFlagCount = 4;

  // Interrupt levels run from 1 (highest) to piLevels, 0 means no level
  localparam int piLevels = 7;
  localparam int levelWidth = 3;

  // Width of the interval meter period and count
  localparam int meterWidth = 16;

endpackage

`default_nettype wire

// File: verilog/aprCondition.sv
`timescale 1ns/1ps
`default_nettype none

module aprCondition (
  input wire clk,
  input wire reset,
  input wire ebusDemand,
  input wire [ebusPkg::csWidth-1:0] ebusCs,
  input wire [ebusPkg::funcWidth-1:0] ebusFunc,
  input wire [ebusPkg::dataWidth-1:0] ebusDataIn,
  output logic aprDriving,
  output logic [ebusPkg::dataWidth-1:0] aprData,
  output logic aprRequest,
  output logic [devicePkg::levelWidth-1:0] aprLevel
);

  ebusPkg::ebusWord word;
  ebusPkg::ebusWord readWord;
  logic selected;
  logic conoHit;
  logic coniHit;
  logic [devicePkg::aprFlagCount-1:0] flags;

  assign word.data = ebusDataIn;

  assign selected = ebusDemand && (ebusCs == devicePkg::devApr);
  assign conoHit = selected && (ebusFunc == ebusPkg::funcCono);
  assign coniHit = selected && (ebusFunc == ebusPkg::funcConi);

  // Clear is applied before set, so a flag named in both ends up set
  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= '0;
      aprLevel <= '0;
    end else if (conoHit) begin
      flags <= (flags & ~word.cond.clearBits[devicePkg::aprFlagCount-1:0])
             | word.cond.setBits[devicePkg::aprFlagCount-1:0];
      aprLevel <= word.cond.level;
    end
  end

  // CONI word has flags in the low bits with the level just above them
  always_comb begin
    readWord.data = '0;
    readWord.data[devicePkg::aprFlagCount-1:0] = flags;
    readWord.data[devicePkg::aprFlagCount +: devicePkg::levelWidth] = aprLevel;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      aprDriving <= 1'b0;
    end else begin
      aprDriving <= coniHit;
    end
  end

  always_ff @(posedge clk) begin
    if (coniHit) begin
      aprData <= readWord.data;
    end
  end

  // Level 0 disconnects the block from the interrupt system
  assign aprRequest = (|flags) && (aprLevel != '0);

  // Back-to-back bus cycles only happen for back-to-back CONI demands on the bus
  aprDriveOnce: assert property (
    @(posedge clk) disable iff (reset)
    aprDriving && $past(aprDriving) |->
      $past(ebusDemand, 2) && ($past(ebusCs, 2) == devicePkg::devApr)
      && ($past(ebusFunc, 2) == ebusPkg::funcConi)
      && $past(ebusDemand) && ($past(ebusCs) == devicePkg::devApr)
      && ($past(ebusFunc) == ebusPkg::funcConi)
  );

endmodule

`default_nettype wire

// File: verilog/piPriority.sv
`timescale 1ns/1ps
`default_nettype none

module piPriority (
  input wire clk,
  input wire reset,
  input wire ebusDemand,
  input wire [ebusPkg::csWidth-1:0] ebusCs,
  input wire [ebusPkg::funcWidth-1:0] ebusFunc,
  input wire [ebusPkg::dataWidth-1:0] ebusDataIn,
  input wire aprRequest,
  input wire [devicePkg::levelWidth-1:0] aprLevel,
  input wire mtrRequest,
  input wire [devicePkg::levelWidth-1:0] mtrLevel,
  output logic piDriving,
  output logic [ebusPkg::dataWidth-1:0] piData,
  output logic [devicePkg::levelWidth-1:0] piLevel
);

  localparam int n = devicePkg::piLevels;

  ebusPkg::ebusWord word;
  ebusPkg::ebusWord readWord;
  logic selected;
  logic conoHit;
  logic coniHit;
  logic sysOn;

  // Bit i of each set stands for level i+1
  logic [n-1:0] enables;
  logic [n-1:0] pending;
  logic [n-1:0] active;
  logic [devicePkg::levelWidth-1:0] best;
  logic [n-1:0] levelMask;

  assign word.data = ebusDataIn;

  assign selected = ebusDemand && (ebusCs == devicePkg::devPi);
  assign conoHit = selected && (ebusFunc == ebusPkg::funcCono);
  assign coniHit = selected && (ebusFunc == ebusPkg::funcConi);

  always_ff @(posedge clk) begin
    if (reset) begin
      enables <= '0;
      sysOn <= 1'b0;
    end else if (conoHit) begin
      // A level named in both setBits and clearBits stays enabled
      enables <= (enables & ~word.cond.clearBits) | word.cond.setBits;
      if (word.cond.turnOn) begin
        sysOn <= 1'b1;
      end else if (word.cond.turnOff) begin
        sysOn <= 1'b0;
      end
    end
  end

  // Requests on level 0 are not connected to any level
  always_comb begin
    pending = '0;
    if (aprRequest && (aprLevel != '0)) begin
      pending[aprLevel - 1'b1] = 1'b1;
    end
    if (mtrRequest && (mtrLevel != '0)) begin
      pending[mtrLevel - 1'b1] = 1'b1;
    end
  end

  assign active = pending & enables & {n{sysOn}};

  // Scan from the lowest priority up so the lowest-numbered level wins
  always_comb begin
    best = '0;
    for (int i = n - 1; i >= 0; i--) begin
      if (active[i]) begin
        best = devicePkg::levelWidth'(i + 1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      piLevel <= '0;
    end else begin
      piLevel <= best;
    end
  end

  // CONI word is pending set, then enables, then the system-on bit
  always_comb begin
    readWord.data = '0;
    readWord.data[n-1:0] = pending;
    readWord.data[2*n-1:n] = enables;
    readWord.data[2*n] = sysOn;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      piDriving <= 1'b0;
    end else begin
      piDriving <= coniHit;
    end
  end

  always_ff @(posedge clk) begin
    if (coniHit) begin
      piData <= readWord.data;
    end
  end

  assign levelMask = {{(n-1){1'b0}}, 1'b1} << (piLevel - 1'b1);

  // The granted level was enabled, with the system on, when it was chosen
  piGrantEnabled: assert property (
    @(posedge clk) disable iff (reset)
    piLevel != '0 |-> $past(sysOn) && |($past(enables) & levelMask)
  );

endmodule

`default_nettype wire

// File: verilog/intervalMeter.sv
`timescale 1ns/1ps
`default_nettype none

module intervalMeter (
  input wire clk,
  input wire reset,
  input wire ebusDemand,
  input wire [ebusPkg::csWidth-1:0] ebusCs,
  input wire [ebusPkg::funcWidth-1:0] ebusFunc,
  input wire [ebusPkg::dataWidth-1:0] ebusDataIn,
  output logic mtrDriving,
  output logic [ebusPkg::dataWidth-1:0] mtrData,
  output logic mtrRequest,
  output logic [devicePkg::levelWidth-1:0] mtrLevel
);

  localparam int w = devicePkg::meterWidth;

  ebusPkg::ebusWord word;
  ebusPkg::ebusWord readWord;
  logic selected;
  logic conoHit;
  logic coniHit;
  logic dataoHit;
  logic dataiHit;
  logic running;
  logic done;
  logic wrap;
  logic [w-1:0] period;
  logic [w-1:0] count;

  assign word.data = ebusDataIn;

  assign selected = ebusDemand && (ebusCs == devicePkg::devMtr);
  assign conoHit = selected && (ebusFunc == ebusPkg::funcCono);
  assign coniHit = selected && (ebusFunc == ebusPkg::funcConi);
  assign dataoHit = selected && (ebusFunc == ebusPkg::funcDatao);
  assign dataiHit = selected && (ebusFunc == ebusPkg::funcDatai);

  // A period load restarts the count, so it suppresses the wrap
  assign wrap = running && (period != '0) && (count == period - 1'b1) && !dataoHit;

  always_ff @(posedge clk) begin
    if (reset) begin
      running <= 1'b0;
      mtrLevel <= '0;
      period <= '0;
      count <= '0;
    end else begin
      if (conoHit) begin
        if (word.cond.turnOn) begin
          running <= 1'b1;
        end else if (word.cond.turnOff) begin
          running <= 1'b0;
        end
        mtrLevel <= word.cond.level;
      end
      if (dataoHit) begin
        period <= word.data[w-1:0];
        count <= '0;
      end else if (wrap) begin
        count <= '0;
      end else if (running && (period != '0)) begin
        count <= count + 1'b1;
      end
    end
  end

  // A wrap in the same cycle as a clear leaves done set
  always_ff @(posedge clk) begin
    if (reset) begin
      done <= 1'b0;
    end else if (wrap) begin
      done <= 1'b1;
    end else if (conoHit && word.cond.clearBits[0]) begin
      done <= 1'b0;
    end
  end

  assign mtrRequest = done;

  // DATAI reads the count, CONI reads level, done and running from bit 0 up
  always_comb begin
    readWord.data = '0;
    if (dataiHit) begin
      readWord.data[w-1:0] = count;
    end else begin
      readWord.data[devicePkg::levelWidth-1:0] = mtrLevel;
      readWord.data[devicePkg::levelWidth] = done;
      readWord.data[devicePkg::levelWidth+1] = running;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mtrDriving <= 1'b0;
    end else begin
      mtrDriving <= coniHit || dataiHit;
    end
  end

  always_ff @(posedge clk) begin
    if (coniHit || dataiHit) begin
      mtrData <= readWord.data;
    end
  end

  mtrCountInRange: assert property (
    @(posedge clk) disable iff (reset)
    running && (period != '0) |-> count < period
  );

endmodule

`default_nettype wire

// File: verilog/ebusMux.sv
`timescale 1ns/1ps
`default_nettype none

module ebusMux (
  input wire aprDriving,
  input wire [ebusPkg::dataWidth-1:0] aprData,
  input wire piDriving,
  input wire [ebusPkg::dataWidth-1:0] piData,
  input wire mtrDriving,
  input wire [ebusPkg::dataWidth-1:0] mtrData,
  output logic [ebusPkg::dataWidth-1:0] ebusData,
  output logic ebusValid
);

  logic [2:0] drivers;

  assign drivers = {aprDriving, piDriving, mtrDriving};

  // Fixed priority, APR first, then PI, then MTR
  always_comb begin
    if (aprDriving) ebusData = aprData;
    else if (piDriving) ebusData = piData;
    else if (mtrDriving) ebusData = mtrData;
    else ebusData = '0;
  end

  assign ebusValid = |drivers;

  // Devices only answer their own select, so two drivers means a decode clash
  always_comb begin
    ebusOneDriver: assert final ($isunknown(drivers) || $onehot0(drivers))
      else $error("more than one device driving EBUS: %b", drivers);
  end

endmodule

`default_nettype wire

// File: verilog/ebusTop.sv
`timescale 1ns/1ps
`default_nettype none

module ebusTop (
  input wire clk,
  input wire reset,
  input wire ebusDemand,
  input wire [ebusPkg::csWidth-1:0] ebusCs,
  input wire [ebusPkg::funcWidth-1:0] ebusFunc,
  input wire [ebusPkg::dataWidth-1:0] ebusDataIn,
  output logic [ebusPkg::dataWidth-1:0] ebusData,
  output logic ebusValid,
  output logic [devicePkg::levelWidth-1:0] piLevel
);

  logic aprDriving;
  logic [ebusPkg::dataWidth-1:0] aprData;
  logic aprRequest;
  logic [devicePkg::levelWidth-1:0] aprLevel;

  logic piDriving;
  logic [ebusPkg::dataWidth-1:0] piData;

  logic mtrDriving;
  logic [ebusPkg::dataWidth-1:0] mtrData;
  logic mtrRequest;
  logic [devicePkg::levelWidth-1:0] mtrLevel;

  aprCondition apr (
    .clk(clk),
    .reset(reset),
    .ebusDemand(ebusDemand),
    .ebusCs(ebusCs),
    .ebusFunc(ebusFunc),
    .ebusDataIn(ebusDataIn),
    .aprDriving(aprDriving),
    .aprData(aprData),
    .aprRequest(aprRequest),
    .aprLevel(aprLevel)
  );

  // The PI block sees the raw requests and levels of the other two devices
  piPriority pi (
    .clk(clk),
    .reset(reset),
    .ebusDemand(ebusDemand),
    .ebusCs(ebusCs),
    .ebusFunc(ebusFunc),
    .ebusDataIn(ebusDataIn),
    .aprRequest(aprRequest),
    .aprLevel(aprLevel),
    .mtrRequest(mtrRequest),
    .mtrLevel(mtrLevel),
    .piDriving(piDriving),
    .piData(piData),
    .piLevel(piLevel)
  );

  intervalMeter mtr (
    .clk(clk),
    .reset(reset),
    .ebusDemand(ebusDemand),
    .ebusCs(ebusCs),
    .ebusFunc(ebusFunc),
    .ebusDataIn(ebusDataIn),
    .mtrDriving(mtrDriving),
    .mtrData(mtrData),
    .mtrRequest(mtrRequest),
    .mtrLevel(mtrLevel)
  );

  ebusMux mux (
    .aprDriving(aprDriving),
    .aprData(aprData),
    .piDriving(piDriving),
    .piData(piData),
    .mtrDriving(mtrDriving),
    .mtrData(mtrData),
    .ebusData(ebusData),
    .ebusValid(ebusValid)
  );

endmodule

`default_nettype wire

// File: test/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen (
  output logic clk,
  output logic reset
);

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Reset is seen by the first two rising edges
  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

// File: test/ebusTb.sv
`timescale 1ns/1ps
`default_nettype none

module ebusTb;

  localparam int randomOps = 60;
  localparam int opCount = randomOps + 40;
  localparam int meterPeriod = 5;
  localparam int watchdogCycles = opCount * 4 + meterPeriod * 3 + 100;
  localparam logic [ebusPkg::dataWidth-1:0] allBits = '1;
  localparam logic [ebusPkg::dataWidth-1:0] doneMask = 36'h8;

  logic clk;
  logic reset;
  logic ebusDemand;
  logic [ebusPkg::csWidth-1:0] ebusCs;
  logic [ebusPkg::funcWidth-1:0] ebusFunc;
  logic [ebusPkg::dataWidth-1:0] ebusDataIn;
  logic [ebusPkg::dataWidth-1:0] ebusData;
  logic ebusValid;
  logic [devicePkg::levelWidth-1:0] piLevel;

  // Expectation that travels with a demand, then is held for the answer cycle
  logic nextArm = 1'b0;
  logic nextValid;
  logic [ebusPkg::dataWidth-1:0] nextData;
  logic [ebusPkg::dataWidth-1:0] nextMask;
  logic chkArm;
  logic chkValid;
  logic [ebusPkg::dataWidth-1:0] chkData;
  logic [ebusPkg::dataWidth-1:0] chkMask;

  // Reference state of the devices
  logic [3:0] aprFlags = '0;
  logic [2:0] aprLvl = '0;
  logic [6:0] piEn = '0;
  logic piOn = 1'b0;
  logic mtrOn = 1'b0;
  logic mtrDone = 1'b0;
  logic [2:0] mtrLvl = '0;

  integer seed;
  int cycleCount = 0;
  int errorCount = 0;

  clockGen clocks (
    .clk(clk),
    .reset(reset)
  );

  ebusTop dut_i (
    .clk(clk),
    .reset(reset),
    .ebusDemand(ebusDemand),
    .ebusCs(ebusCs),
    .ebusFunc(ebusFunc),
    .ebusDataIn(ebusDataIn),
    .ebusData(ebusData),
    .ebusValid(ebusValid),
    .piLevel(piLevel)
  );

  task automatic reportMismatch(input string name, input logic [35:0] expected,
                                input logic [35:0] actual);
    errorCount++;
    $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic reportProblem(input string what);
    errorCount++;
    $display("** Error at %0t ns: %s", $time, what);
    $display("Testbench failed");
    $fatal(1);
  endtask

  function automatic logic [35:0] condData(input logic [6:0] clearMask,
                                           input logic [6:0] setMask, input logic off,
                                           input logic on, input logic [2:0] lvl);
    ebusPkg::ebusWord w;
    w.data = '0;
    w.cond.clearBits = clearMask;
    w.cond.setBits = setMask;
    w.cond.turnOff = off;
    w.cond.turnOn = on;
    w.cond.level = lvl;
    return w.data;
  endfunction

  // Bit k stands for level k+1 and level 0 requests go nowhere
  function automatic logic [6:0] pendingSet();
    logic [6:0] pend;
    pend = '0;
    if ((aprFlags != 4'd0) && (aprLvl != 3'd0)) pend[aprLvl - 3'd1] = 1'b1;
    if (mtrDone && (mtrLvl != 3'd0)) pend[mtrLvl - 3'd1] = 1'b1;
    return pend;
  endfunction

  function automatic logic [2:0] bestLevel();
    logic [6:0] active;
    logic [2:0] level;
    active = pendingSet() & piEn & {7{piOn}};
    level = 3'd0;
    for (int lvl = 1; lvl <= 7; lvl++) begin
      if (active[lvl-1] && (level == 3'd0)) level = 3'(lvl);
    end
    return level;
  endfunction

  function automatic logic answers(input logic [6:0] cs, input logic [2:0] func);
    if (func == ebusPkg::funcConi) begin
      return (cs == devicePkg::devApr) || (cs == devicePkg::devPi) || (cs == devicePkg::devMtr);
    end
    return (cs == devicePkg::devMtr) && (func == ebusPkg::funcDatai);
  endfunction

  // Expected read word from the model. The meter count is not modelled here
  function automatic logic [35:0] expectRead(input logic [6:0] cs, input logic [2:0] func);
    logic [35:0] result;
    result = '0;
    if (func == ebusPkg::funcConi) begin
      if (cs == devicePkg::devApr) begin
        result[3:0] = aprFlags;
        result[6:4] = aprLvl;
      end else if (cs == devicePkg::devPi) begin
        result[6:0] = pendingSet();
        result[13:7] = piEn;
        result[14] = piOn;
      end else if (cs == devicePkg::devMtr) begin
        result[2:0] = mtrLvl;
        result[3] = mtrDone;
        result[4] = mtrOn;
      end
    end
    return result;
  endfunction

  function automatic void applyCono(input logic [6:0] cs, input logic [35:0] data);
    ebusPkg::ebusWord w;
    w.data = data;
    if (cs == devicePkg::devApr) begin
      aprFlags = (aprFlags & ~w.cond.clearBits[3:0]) | w.cond.setBits[3:0];
      aprLvl = w.cond.level;
    end else if (cs == devicePkg::devPi) begin
      piEn = (piEn & ~w.cond.clearBits) | w.cond.setBits;
      if (w.cond.turnOn) piOn = 1'b1;
      else if (w.cond.turnOff) piOn = 1'b0;
    end else if (cs == devicePkg::devMtr) begin
      if (w.cond.turnOn) mtrOn = 1'b1;
      else if (w.cond.turnOff) mtrOn = 1'b0;
      mtrLvl = w.cond.level;
      if (w.cond.clearBits[0]) mtrDone = 1'b0;
    end
  endfunction

  task automatic issue(input logic [6:0] cs, input logic [2:0] func,
                       input logic [35:0] data, input logic [35:0] mask);
    @(posedge clk);
    if (func == ebusPkg::funcCono) applyCono(cs, data);
    ebusDemand <= 1'b1;
    ebusCs <= cs;
    ebusFunc <= func;
    ebusDataIn <= data;
    nextArm <= 1'b1;
    nextValid <= answers(cs, func);
    nextData <= expectRead(cs, func);
    nextMask <= mask;
  endtask

  task automatic idle();
    @(posedge clk);
    ebusDemand <= 1'b0;
    nextArm <= 1'b0;
  endtask

  task automatic checkLevel();
    logic [2:0] expected;
    expected = bestLevel();
    assert (piLevel === expected)
      else reportMismatch("piLevel", 36'(expected), 36'(piLevel));
  endtask

  // piLevel settles two edges after the CONO is driven
  task automatic conoAndCheckLevel(input logic [6:0] cs, input logic [35:0] data);
    issue(cs, ebusPkg::funcCono, data, allBits);
    idle();
    @(posedge clk);
    @(negedge clk);
    checkLevel();
  endtask

  task automatic checkMeterCount();
    issue(devicePkg::devMtr, ebusPkg::funcDatai, '0, '0);
    idle();
    @(negedge clk);
    assert (ebusData < meterPeriod)
      else reportProblem($sformatf("meter count %0d is not below period %0d",
                                   ebusData, meterPeriod));
  endtask

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (reset) begin
      chkArm <= 1'b0;
    end else begin
      chkArm <= nextArm;
    end
    chkValid <= nextValid;
    chkData <= nextData;
    chkMask <= nextMask;
  end

  // Outputs are compared at the falling edge, half a cycle after they change
  always @(negedge clk) begin
    if (chkArm) begin
      assert (ebusValid === chkValid)
        else reportMismatch("ebusValid", 36'(chkValid), 36'(ebusValid));
      if (chkValid) begin
        assert ((ebusData & chkMask) === (chkData & chkMask))
          else reportMismatch("ebusData", chkData & chkMask, ebusData & chkMask);
      end
    end else if (!reset) begin
      assert (ebusValid === 1'b0)
        else reportMismatch("ebusValid", 36'd0, 36'(ebusValid));
    end
  end

  initial begin
    repeat (watchdogCycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d clock cycles", watchdogCycles);
    $display("Testbench failed");
    $fatal(1);
  end

  initial begin
    logic [31:0] r;
    logic doneSeen;
    int startCycle;
    int sampleCycle;
    seed = 32'h073809ec;
    ebusDemand = 1'b0;
    ebusCs = '0;
    ebusFunc = '0;
    ebusDataIn = '0;
    wait (reset === 1'b0);

    // Reset state
    @(negedge clk);
    checkLevel();
    issue(devicePkg::devApr, ebusPkg::funcConi, '0, allBits);
    issue(devicePkg::devPi, ebusPkg::funcConi, '0, allBits);
    issue(devicePkg::devMtr, ebusPkg::funcConi, '0, allBits);
    idle();

    // Random APR traffic with many back-to-back demands
    for (int i = 0; i < randomOps; i++) begin
      r = $random(seed);
      if (r[0]) begin
        issue(devicePkg::devApr, ebusPkg::funcCono,
              condData(r[10:4], r[17:11], 1'b0, 1'b0, r[20:18]), allBits);
      end else begin
        issue(devicePkg::devApr, ebusPkg::funcConi, '0, allBits);
      end
      if (r[1]) idle();
    end
    idle();

    // Priority selection against APR requests
    conoAndCheckLevel(devicePkg::devApr, condData(7'h0f, 7'h05, 1'b0, 1'b0, 3'd3));
    conoAndCheckLevel(devicePkg::devPi, condData(7'h00, 7'h04, 1'b0, 1'b1, 3'd0));
    conoAndCheckLevel(devicePkg::devPi, condData(7'h04, 7'h00, 1'b0, 1'b0, 3'd0));
    conoAndCheckLevel(devicePkg::devPi, condData(7'h00, 7'h7f, 1'b0, 1'b0, 3'd0));
    conoAndCheckLevel(devicePkg::devApr, condData(7'h00, 7'h00, 1'b0, 1'b0, 3'd5));
    conoAndCheckLevel(devicePkg::devPi, condData(7'h00, 7'h00, 1'b1, 1'b0, 3'd0));
    conoAndCheckLevel(devicePkg::devPi, condData(7'h00, 7'h00, 1'b0, 1'b1, 3'd0));
    conoAndCheckLevel(devicePkg::devApr, condData(7'h0f, 7'h00, 1'b0, 1'b0, 3'd5));
    conoAndCheckLevel(devicePkg::devApr, condData(7'h00, 7'h02, 1'b0, 1'b0, 3'd2));
    conoAndCheckLevel(devicePkg::devPi, condData(7'h7f, 7'h02, 1'b0, 1'b0, 3'd0));
    issue(devicePkg::devPi, ebusPkg::funcConi, '0, allBits);
    idle();

    // Interval meter on level 4 below APR on level 6
    conoAndCheckLevel(devicePkg::devPi, condData(7'h00, 7'h7f, 1'b0, 1'b0, 3'd0));
    conoAndCheckLevel(devicePkg::devApr, condData(7'h00, 7'h01, 1'b0, 1'b0, 3'd6));
    issue(devicePkg::devMtr, ebusPkg::funcDatao, 36'(meterPeriod), allBits);
    idle();
    issue(devicePkg::devMtr, ebusPkg::funcCono, condData(7'h00, 7'h00, 1'b0, 1'b1, 3'd4),
          allBits);
    idle();
    startCycle = cycleCount;
    doneSeen = 1'b0;
    while (!doneSeen) begin
      issue(devicePkg::devMtr, ebusPkg::funcConi, '0, ~doneMask);
      idle();
      sampleCycle = cycleCount;
      @(negedge clk);
      doneSeen = ebusData[3];
      assert (doneSeen || (sampleCycle - startCycle < meterPeriod + 2))
        else reportProblem("meter done flag did not set within period plus 2 cycles");
    end
    mtrDone = 1'b1;
    idle();
    idle();
    @(negedge clk);
    checkLevel();
    checkMeterCount();
    issue(devicePkg::devPi, ebusPkg::funcConi, '0, allBits);
    idle();

    // Stop the meter first so that no later wrap sets done again
    issue(devicePkg::devMtr, ebusPkg::funcCono, condData(7'h00, 7'h00, 1'b1, 1'b0, 3'd4),
          allBits);
    idle();
    conoAndCheckLevel(devicePkg::devMtr, condData(7'h01, 7'h00, 1'b0, 1'b0, 3'd4));
    issue(devicePkg::devMtr, ebusPkg::funcConi, '0, allBits);
    idle();
    checkMeterCount();

    // Reads that nobody answers
    issue(7'd5, ebusPkg::funcConi, '0, allBits);
    issue(devicePkg::devApr, ebusPkg::funcDatai, '0, allBits);
    issue(devicePkg::devPi, ebusPkg::funcDatai, '0, allBits);
    idle();
    idle();
    @(negedge clk);

    if (errorCount == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      $display("Testbench failed");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

// File: src.f
verilog/ebusPkg.sv
verilog/devicePkg.sv
verilog/aprCondition.sv
verilog/piPriority.sv
verilog/intervalMeter.sv
verilog/ebusMux.sv
verilog/ebusTop.sv
test/clockGen.sv
test/ebusTb.sv
